/* rtl/rv_core_settings.svh */
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Width of data words and byte addresses.
`define XLEN 32

// Depth of the shared RAM in 32-bit words.
// Instructions and data live in the same array.
`define MEM_WORDS 1024

// Byte address of the first instruction fetched after reset.
`define RESET_PC 32'h0000_0000

`endif

/* rtl/rv_types_pkg.sv */
`include "rv_core_settings.svh"

package rv_types_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_addr_t;

    // Codes follow funct3 of the RISC-V load and store instructions.
    // Code 3 is unused by RV32I loads and marks a slot without memory access.
    typedef enum logic [2:0] {
        LSU_LB   = 3'd0,
        LSU_LH   = 3'd1,
        LSU_LW   = 3'd2,
        LSU_NONE = 3'd3,
        LSU_LBU  = 3'd4,
        LSU_LHU  = 3'd5
    } lsu_op_t;

    // Stores share the load codes. The memory write signal tells them apart.
    localparam lsu_op_t LSU_SB = LSU_LB;
    localparam lsu_op_t LSU_SH = LSU_LH;
    localparam lsu_op_t LSU_SW = LSU_LW;

    typedef enum logic [1:0] {
        DEST_ALU = 2'd0,
        DEST_MEM = 2'd1,
        DEST_PC4 = 2'd2
    } data_dest_t;

endpackage

/* rtl/mem_bus_pkg.sv */
`include "rv_core_settings.svh"

package mem_bus_pkg;

    // Word index into the shared RAM.
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;

    // One enable per byte lane of a word.
    typedef logic [`XLEN/8-1:0] byte_en_t;

    // Who issued the read whose data comes back in the next cycle.
    typedef enum logic [1:0] {
        OWNER_NONE  = 2'd0,
        OWNER_FETCH = 2'd1,
        OWNER_LSU   = 2'd2
    } bus_owner_t;

endpackage

/* rtl/ex_mem_register.sv */
module ex_mem_register
    import rv_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  word_t      new_pc_i,
    input  logic       br_taken_i,
    input  word_t      pc_plus4_i,
    input  word_t      alu_result_i,
    input  word_t      rs2_i,
    input  data_dest_t data_dest_i,
    input  lsu_op_t    lsu_op_i,
    input  reg_addr_t  reg_wr_addr_i,
    input  logic       reg_wr_sig_i,
    input  logic       mem_wr_sig_i,

    output word_t      new_pc_o,
    output logic       br_taken_o,
    output word_t      pc_plus4_o,
    output word_t      alu_result_o,
    output word_t      rs2_o,
    output data_dest_t data_dest_o,
    output lsu_op_t    lsu_op_o,
    output reg_addr_t  reg_wr_addr_o,
    output logic       reg_wr_sig_o,
    output logic       mem_wr_sig_o
);

    // The instruction behind a taken branch is on the wrong path.
    // It is replaced by an all-zero slot, which writes neither a register nor memory.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            new_pc_o      <= '0;
            br_taken_o    <= 1'b0;
            pc_plus4_o    <= '0;
            alu_result_o  <= '0;
            rs2_o         <= '0;
            data_dest_o   <= data_dest_t'('0);
            lsu_op_o      <= lsu_op_t'('0);
            reg_wr_addr_o <= '0;
            reg_wr_sig_o  <= 1'b0;
            mem_wr_sig_o  <= 1'b0;
        end else if (br_taken_o) begin
            new_pc_o      <= '0;
            br_taken_o    <= 1'b0;
            pc_plus4_o    <= '0;
            alu_result_o  <= '0;
            rs2_o         <= '0;
            data_dest_o   <= data_dest_t'('0);
            lsu_op_o      <= lsu_op_t'('0);
            reg_wr_addr_o <= '0;
            reg_wr_sig_o  <= 1'b0;
            mem_wr_sig_o  <= 1'b0;
        end else begin
            new_pc_o      <= new_pc_i;
            br_taken_o    <= br_taken_i;
            pc_plus4_o    <= pc_plus4_i;
            alu_result_o  <= alu_result_i;
            rs2_o         <= rs2_i;
            data_dest_o   <= data_dest_i;
            lsu_op_o      <= lsu_op_i;
            reg_wr_addr_o <= reg_wr_addr_i;
            reg_wr_sig_o  <= reg_wr_sig_i;
            mem_wr_sig_o  <= mem_wr_sig_i;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
`include "rv_core_settings.svh"

module fetch_unit
    import rv_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      redirect_i,
    input  word_t     redirect_pc_i,
    input  logic      grant_i,
    input  logic      rdata_valid_i,
    input  word_t     rdata_i,
    output logic      req_o,
    output mem_addr_t addr_o,
    output logic      instr_valid_o,
    output word_t     instr_o,
    output word_t     instr_pc_o
);

    word_t pc_q;
    word_t read_pc_q;
    logic  read_live_q;

    // Fetch always wants the port. The arbiter decides when it gets it.
    assign req_o  = 1'b1;
    assign addr_o = pc_q[$bits(mem_addr_t)+1:2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q        <= `RESET_PC;
            read_live_q <= 1'b0;
        end else if (redirect_i) begin
            // A read issued on this edge belongs to the old path and is dropped.
            pc_q        <= redirect_pc_i;
            read_live_q <= 1'b0;
        end else begin
            // Returning data is stale only right after a redirect.
            read_live_q <= 1'b1;
            if (grant_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_i) begin
            read_pc_q <= pc_q;
        end
    end

    assign instr_valid_o = read_live_q & rdata_valid_i;
    assign instr_o       = rdata_i;
    assign instr_pc_o    = read_pc_q;

endmodule

/* rtl/load_store_unit.sv */
module load_store_unit
    import rv_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  lsu_op_t   lsu_op_i,
    input  logic      mem_wr_sig_i,
    input  word_t     addr_i,
    input  word_t     store_data_i,
    input  word_t     rdata_i,
    output logic      req_o,
    output logic      we_o,
    output mem_addr_t addr_o,
    output byte_en_t  be_o,
    output word_t     wdata_o,
    output word_t     load_data_o
);

    logic [1:0]  offset;
    lsu_op_t     op_q;
    logic [1:0]  offset_q;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign offset = addr_i[1:0];
    assign req_o  = (lsu_op_i != LSU_NONE);
    assign we_o   = req_o & mem_wr_sig_i;
    assign addr_o = addr_i[$bits(mem_addr_t)+1:2];

    // Narrow stores copy their data into every lane and enable only the addressed ones.
    always_comb begin
        case (lsu_op_i)
            LSU_SB: begin
                wdata_o = {4{store_data_i[7:0]}};
                be_o    = byte_en_t'(4'b0001 << offset);
            end
            LSU_SH: begin
                wdata_o = {2{store_data_i[15:0]}};
                be_o    = offset[1] ? 4'b1100 : 4'b0011;
            end
            LSU_SW: begin
                wdata_o = store_data_i;
                be_o    = 4'b1111;
            end
            default: begin
                wdata_o = store_data_i;
                be_o    = 4'b0000;
            end
        endcase
    end

    // The RAM answers one edge later, so the op and offset are kept for that cycle.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            op_q     <= LSU_NONE;
            offset_q <= 2'b00;
        end else begin
            op_q     <= lsu_op_i;
            offset_q <= offset;
        end
    end

    always_comb begin
        byte_lane = rdata_i[{offset_q, 3'b000} +: 8];
        half_lane = offset_q[1] ? rdata_i[31:16] : rdata_i[15:0];
        case (op_q)
            LSU_LB:  load_data_o = {{24{byte_lane[7]}}, byte_lane};
            LSU_LBU: load_data_o = {24'b0, byte_lane};
            LSU_LH:  load_data_o = {{16{half_lane[15]}}, half_lane};
            LSU_LHU: load_data_o = {16'b0, half_lane};
            LSU_LW:  load_data_o = rdata_i;
            default: load_data_o = '0;
        endcase
    end

endmodule

/* rtl/mem_arbiter.sv */
module mem_arbiter
    import rv_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      lsu_req_i,
    input  logic      lsu_we_i,
    input  mem_addr_t lsu_addr_i,
    input  byte_en_t  lsu_be_i,
    input  word_t     lsu_wdata_i,
    input  logic      fetch_req_i,
    input  mem_addr_t fetch_addr_i,
    input  word_t     ram_rdata_i,
    output logic      fetch_grant_o,
    output logic      fetch_rdata_valid_o,
    output logic      ram_en_o,
    output logic      ram_we_o,
    output mem_addr_t ram_addr_o,
    output byte_en_t  ram_be_o,
    output word_t     ram_wdata_o,
    output word_t     rdata_o
);

    bus_owner_t owner_q;

    // The load/store unit always wins. Fetch only gets the port when it is idle.
    assign fetch_grant_o = fetch_req_i & ~lsu_req_i;
    assign ram_en_o      = lsu_req_i | fetch_req_i;
    assign ram_we_o      = lsu_req_i & lsu_we_i;
    assign ram_addr_o    = lsu_req_i ? lsu_addr_i : fetch_addr_i;
    assign ram_be_o      = ram_we_o ? lsu_be_i : '0;
    assign ram_wdata_o   = lsu_wdata_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            owner_q <= OWNER_NONE;
        end else if (lsu_req_i && !lsu_we_i) begin
            owner_q <= OWNER_LSU;
        end else if (fetch_grant_o) begin
            owner_q <= OWNER_FETCH;
        end else begin
            owner_q <= OWNER_NONE;
        end
    end

    assign fetch_rdata_valid_o = (owner_q == OWNER_FETCH);
    assign rdata_o             = (owner_q == OWNER_NONE) ? '0 : ram_rdata_i;

endmodule

/* rtl/unified_ram.sv */
`include "rv_core_settings.svh"

module unified_ram
    import rv_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      en_i,
    input  logic      we_i,
    input  mem_addr_t addr_i,
    input  byte_en_t  be_i,
    input  word_t     wdata_i,
    output word_t     rdata_o
);

    word_t mem [`MEM_WORDS] = '{default: '0};

    // Read returns the old contents when the same word is written in that cycle.
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
            if (we_i) begin
                for (int lane = 0; lane < $bits(byte_en_t); lane++) begin
                    if (be_i[lane]) begin
                        mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

/* rtl/writeback_select.sv */
module writeback_select
    import rv_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       reg_wr_sig_i,
    input  reg_addr_t  reg_wr_addr_i,
    input  data_dest_t data_dest_i,
    input  word_t      alu_result_i,
    input  word_t      pc_plus4_i,
    input  word_t      load_data_i,
    output logic       rd_we_o,
    output reg_addr_t  rd_addr_o,
    output word_t      rd_data_o
);

    data_dest_t dest_q;
    word_t      alu_result_q;
    word_t      pc_plus4_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_we_o   <= 1'b0;
            rd_addr_o <= '0;
            dest_q    <= DEST_ALU;
        end else begin
            rd_we_o   <= reg_wr_sig_i;
            rd_addr_o <= reg_wr_addr_i;
            dest_q    <= data_dest_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_q <= alu_result_i;
        pc_plus4_q   <= pc_plus4_i;
    end

    // Load data arrives straight from the RAM in this cycle, so it is not registered here.
    always_comb begin
        case (dest_q)
            DEST_MEM: rd_data_o = load_data_i;
            DEST_PC4: rd_data_o = pc_plus4_q;
            default:  rd_data_o = alu_result_q;
        endcase
    end

endmodule

/* rtl/mem_stage_top.sv */
module mem_stage_top
    import rv_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  word_t      new_pc_i,
    input  logic       br_taken_i,
    input  word_t      pc_plus4_i,
    input  word_t      alu_result_i,
    input  word_t      rs2_i,
    input  data_dest_t data_dest_i,
    input  lsu_op_t    lsu_op_i,
    input  reg_addr_t  reg_wr_addr_i,
    input  logic       reg_wr_sig_i,
    input  logic       mem_wr_sig_i,
    output logic       rd_we_o,
    output reg_addr_t  rd_addr_o,
    output word_t      rd_data_o,
    output logic       instr_valid_o,
    output word_t      instr_o,
    output word_t      instr_pc_o
);

    word_t      exm_new_pc;
    logic       exm_br_taken;
    word_t      exm_pc_plus4;
    word_t      exm_alu_result;
    word_t      exm_rs2;
    data_dest_t exm_data_dest;
    lsu_op_t    exm_lsu_op;
    reg_addr_t  exm_reg_wr_addr;
    logic       exm_reg_wr_sig;
    logic       exm_mem_wr_sig;

    logic       lsu_req;
    logic       lsu_we;
    mem_addr_t  lsu_addr;
    byte_en_t   lsu_be;
    word_t      lsu_wdata;
    word_t      load_data;

    logic       fetch_req;
    mem_addr_t  fetch_addr;
    logic       fetch_grant;
    logic       fetch_rdata_valid;

    logic       ram_en;
    logic       ram_we;
    mem_addr_t  ram_addr;
    byte_en_t   ram_be;
    word_t      ram_wdata;
    word_t      ram_rdata;
    word_t      bus_rdata;

    ex_mem_register u_ex_mem (
        .clk(clk), .reset_n(reset_n),
        .new_pc_i      (new_pc_i),
        .br_taken_i    (br_taken_i),
        .pc_plus4_i    (pc_plus4_i),
        .alu_result_i  (alu_result_i),
        .rs2_i         (rs2_i),
        .data_dest_i   (data_dest_i),
        .lsu_op_i      (lsu_op_i),
        .reg_wr_addr_i (reg_wr_addr_i),
        .reg_wr_sig_i  (reg_wr_sig_i),
        .mem_wr_sig_i  (mem_wr_sig_i),
        .new_pc_o      (exm_new_pc),
        .br_taken_o    (exm_br_taken),
        .pc_plus4_o    (exm_pc_plus4),
        .alu_result_o  (exm_alu_result),
        .rs2_o         (exm_rs2),
        .data_dest_o   (exm_data_dest),
        .lsu_op_o      (exm_lsu_op),
        .reg_wr_addr_o (exm_reg_wr_addr),
        .reg_wr_sig_o  (exm_reg_wr_sig),
        .mem_wr_sig_o  (exm_mem_wr_sig)
    );

    load_store_unit u_lsu (
        .clk(clk), .reset_n(reset_n),
        .lsu_op_i     (exm_lsu_op),
        .mem_wr_sig_i (exm_mem_wr_sig),
        .addr_i       (exm_alu_result),
        .store_data_i (exm_rs2),
        .rdata_i      (bus_rdata),
        .req_o        (lsu_req),
        .we_o         (lsu_we),
        .addr_o       (lsu_addr),
        .be_o         (lsu_be),
        .wdata_o      (lsu_wdata),
        .load_data_o  (load_data)
    );

    fetch_unit u_fetch (
        .clk(clk), .reset_n(reset_n),
        .redirect_i    (exm_br_taken),
        .redirect_pc_i (exm_new_pc),
        .grant_i       (fetch_grant),
        .rdata_valid_i (fetch_rdata_valid),
        .rdata_i       (bus_rdata),
        .req_o         (fetch_req),
        .addr_o        (fetch_addr),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset_n(reset_n),
        .lsu_req_i           (lsu_req),
        .lsu_we_i            (lsu_we),
        .lsu_addr_i          (lsu_addr),
        .lsu_be_i            (lsu_be),
        .lsu_wdata_i         (lsu_wdata),
        .fetch_req_i         (fetch_req),
        .fetch_addr_i        (fetch_addr),
        .ram_rdata_i         (ram_rdata),
        .fetch_grant_o       (fetch_grant),
        .fetch_rdata_valid_o (fetch_rdata_valid),
        .ram_en_o            (ram_en),
        .ram_we_o            (ram_we),
        .ram_addr_o          (ram_addr),
        .ram_be_o            (ram_be),
        .ram_wdata_o         (ram_wdata),
        .rdata_o             (bus_rdata)
    );

    unified_ram u_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    writeback_select u_writeback (
        .clk(clk), .reset_n(reset_n),
        .reg_wr_sig_i  (exm_reg_wr_sig),
        .reg_wr_addr_i (exm_reg_wr_addr),
        .data_dest_i   (exm_data_dest),
        .alu_result_i  (exm_alu_result),
        .pc_plus4_i    (exm_pc_plus4),
        .load_data_i   (load_data),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o)
    );

endmodule

/* test/tb_mem_stage.sv */
`include "rv_core_settings.svh"

module tb_mem_stage
    import rv_types_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ROWS = 48;
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic reset_n;
    word_t new_pc, pc_plus4, alu_result, rs2;
    logic br_taken, reg_wr_sig, mem_wr_sig;
    data_dest_t data_dest;
    lsu_op_t lsu_op;
    reg_addr_t reg_wr_addr;
    logic rd_we_o, instr_valid_o;
    reg_addr_t rd_addr_o;
    word_t rd_data_o, instr_o, instr_pc_o;

    // Stimulus table and the expected writeback of every row.
    int         row_beh [MAX_ROWS];
    lsu_op_t    row_op [MAX_ROWS];
    logic       row_wr [MAX_ROWS];
    data_dest_t row_dest [MAX_ROWS];
    word_t      row_alu [MAX_ROWS];
    word_t      row_rs2 [MAX_ROWS];
    word_t      row_pc4 [MAX_ROWS];
    reg_addr_t  row_rd [MAX_ROWS];
    logic       row_regwr [MAX_ROWS];
    logic       row_br [MAX_ROWS];
    word_t      row_target [MAX_ROWS];
    logic       row_squash [MAX_ROWS];
    logic       exp_we [MAX_ROWS];
    word_t      exp_data [MAX_ROWS];
    int n_rows = 0;

    // Byte models of the RAM. The first is used while the table is built,
    // the second follows the stores as they reach the DUT.
    logic [7:0] build_mem [256];
    logic [7:0] live_mem [256];

    integer seed = 32'h4057;
    int pass_count = 0;
    int fail_count = 0;
    int beh_errors [1:5];
    int cycle_count = 0;
    int timeout_limit = 100000;
    logic redirect_pending = 1'b0;
    word_t redirect_target;
    word_t last_pc;
    int fetch_checks = 0;
    int redirects_done = 0;

    mem_stage_top DUT (
        .clk(clk), .reset_n(reset_n),
        .new_pc_i(new_pc), .br_taken_i(br_taken), .pc_plus4_i(pc_plus4),
        .alu_result_i(alu_result), .rs2_i(rs2), .data_dest_i(data_dest),
        .lsu_op_i(lsu_op), .reg_wr_addr_i(reg_wr_addr), .reg_wr_sig_i(reg_wr_sig),
        .mem_wr_sig_i(mem_wr_sig),
        .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
        .instr_valid_o(instr_valid_o), .instr_o(instr_o), .instr_pc_o(instr_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("The run timed out after %0d cycles.", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic compare(input int beh, input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %08h expected %08h (behavior %0d, t=%0t)",
                     name, got, exp, beh, $time);
            fail_count++;
            beh_errors[beh]++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic word_t read_model(input logic live, input lsu_op_t op, input int a);
        logic [7:0] b [4];
        for (int k = 0; k < 4; k++) begin
            b[k] = live ? live_mem[(a + k) % 256] : build_mem[(a + k) % 256];
        end
        case (op)
            LSU_LB:  return {{24{b[0][7]}}, b[0]};
            LSU_LBU: return {24'h0, b[0]};
            LSU_LH:  return {{16{b[1][7]}}, b[1], b[0]};
            LSU_LHU: return {16'h0, b[1], b[0]};
            default: return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    task automatic write_model(input logic live, input lsu_op_t op, input int a, input word_t d);
        int count;
        count = (op == LSU_SB) ? 1 : (op == LSU_SH) ? 2 : 4;
        for (int k = 0; k < count; k++) begin
            if (live) begin
                live_mem[(a + k) % 256] = d[k*8 +: 8];
            end else begin
                build_mem[(a + k) % 256] = d[k*8 +: 8];
            end
        end
    endtask

    task automatic add_row(input int beh, input lsu_op_t op, input logic wr, input data_dest_t dest,
                           input word_t alu, input word_t data, input reg_addr_t rd,
                           input logic regwr, input logic br, input word_t target);
        int i;
        i = n_rows;
        row_beh[i] = beh;
        row_op[i] = op;
        row_wr[i] = wr;
        row_dest[i] = dest;
        row_alu[i] = alu;
        row_rs2[i] = data;
        row_pc4[i] = $random(seed);
        row_rd[i] = rd;
        row_regwr[i] = regwr;
        row_br[i] = br;
        row_target[i] = target;
        row_squash[i] = (i > 0) && row_br[i-1] && !row_squash[i-1];
        exp_we[i] = row_squash[i] ? 1'b0 : regwr;
        exp_data[i] = (dest == DEST_PC4) ? row_pc4[i] : alu;
        if (!row_squash[i] && op != LSU_NONE) begin
            if (wr) begin
                write_model(1'b0, op, int'(alu[7:0]), data);
            end else begin
                exp_data[i] = read_model(1'b0, op, int'(alu[7:0]));
            end
        end
        n_rows++;
    endtask

    task automatic alu_row(input int beh, input data_dest_t dest, input reg_addr_t rd, input logic we);
        add_row(beh, LSU_NONE, 1'b0, dest, $random(seed), $random(seed), rd, we, 1'b0, '0);
    endtask

    task automatic store_row(input int beh, input lsu_op_t op, input word_t addr, input word_t data);
        add_row(beh, op, 1'b1, DEST_ALU, addr, data, 5'd0, 1'b0, 1'b0, '0);
    endtask

    task automatic load_row(input int beh, input lsu_op_t op, input word_t addr, input reg_addr_t rd);
        add_row(beh, op, 1'b0, DEST_MEM, addr, '0, rd, 1'b1, 1'b0, '0);
    endtask

    task automatic branch_row(input word_t target);
        add_row(4, LSU_NONE, 1'b0, DEST_ALU, $random(seed), '0, 5'd9, 1'b1, 1'b1, target);
    endtask

    // Each valid fetch must follow the previous one by 4, or land on a pending redirect.
    task automatic check_fetch();
        word_t exp_pc;
        if (instr_valid_o) begin
            exp_pc = redirect_pending ? redirect_target : last_pc + 32'd4;
            if (redirect_pending) begin
                redirects_done++;
            end
            compare((fetch_checks == 0) ? 1 : 5, "instr_pc_o", instr_pc_o, exp_pc);
            compare(5, "instr_o", instr_o, read_model(1'b1, LSU_LW, int'(exp_pc[7:0])));
            redirect_pending = 1'b0;
            last_pc = exp_pc;
            fetch_checks++;
        end
    endtask

    task automatic check_row(input int i);
        compare(row_beh[i], "rd_we_o", word_t'(rd_we_o), word_t'(exp_we[i]));
        if (exp_we[i]) begin
            compare(row_beh[i], "rd_addr_o", word_t'(rd_addr_o), word_t'(row_rd[i]));
            compare(row_beh[i], "rd_data_o", rd_data_o, exp_data[i]);
        end
        if (!row_squash[i] && row_op[i] != LSU_NONE && row_wr[i]) begin
            write_model(1'b1, row_op[i], int'(row_alu[i][7:0]), row_rs2[i]);
        end
        if (row_br[i] && !row_squash[i]) begin
            redirect_pending = 1'b1;
            redirect_target = row_target[i];
        end
    endtask

    task automatic drive_row(input int i);
        new_pc <= row_target[i];
        br_taken <= row_br[i];
        pc_plus4 <= row_pc4[i];
        alu_result <= row_alu[i];
        rs2 <= row_rs2[i];
        data_dest <= row_dest[i];
        lsu_op <= row_op[i];
        reg_wr_addr <= row_rd[i];
        reg_wr_sig <= row_regwr[i];
        mem_wr_sig <= row_wr[i];
    endtask

    task automatic drive_idle();
        br_taken <= 1'b0;
        lsu_op <= LSU_NONE;
        reg_wr_sig <= 1'b0;
        mem_wr_sig <= 1'b0;
    endtask

    initial begin
        reset_n = 1'b0;
        new_pc = '0;
        br_taken = 1'b0;
        pc_plus4 = '0;
        alu_result = '0;
        rs2 = '0;
        data_dest = DEST_ALU;
        lsu_op = LSU_NONE;
        reg_wr_addr = '0;
        reg_wr_sig = 1'b0;
        mem_wr_sig = 1'b0;
        last_pc = `RESET_PC - 32'd4;
        for (int b = 1; b <= 5; b++) begin
            beh_errors[b] = 0;
        end
        for (int a = 0; a < 256; a++) begin
            build_mem[a] = 8'h00;
            live_mem[a] = 8'h00;
        end

        alu_row(2, DEST_ALU, 5'd1, 1'b1);
        alu_row(2, DEST_PC4, 5'd2, 1'b1);
        alu_row(2, DEST_ALU, 5'd3, 1'b0);
        alu_row(2, DEST_ALU, 5'd0, 1'b1);
        store_row(3, LSU_SW, 32'h20, $random(seed));
        store_row(3, LSU_SB, 32'h25, 32'h0000_00a5);
        store_row(3, LSU_SB, 32'h26, 32'h0000_0080);
        store_row(3, LSU_SB, 32'h27, 32'h0000_007f);
        store_row(3, LSU_SH, 32'h2a, 32'h0000_8123);
        store_row(3, LSU_SH, 32'h28, 32'h0000_4567);
        store_row(3, LSU_SW, 32'h30, 32'hfedc_ba98);
        load_row(3, LSU_LW, 32'h20, 5'd4);
        load_row(3, LSU_LB, 32'h25, 5'd5);
        load_row(3, LSU_LB, 32'h27, 5'd6);
        load_row(3, LSU_LBU, 32'h26, 5'd7);
        load_row(3, LSU_LH, 32'h2a, 5'd8);
        load_row(3, LSU_LHU, 32'h2a, 5'd10);
        load_row(3, LSU_LH, 32'h28, 5'd11);
        load_row(3, LSU_LB, 32'h33, 5'd12);
        load_row(3, LSU_LHU, 32'h30, 5'd13);
        load_row(3, LSU_LW, 32'h24, 5'd14);
        alu_row(5, DEST_ALU, 5'd15, 1'b1);
        branch_row(32'h20);
        store_row(4, LSU_SW, 32'h34, 32'h1357_9bdf);
        alu_row(4, DEST_ALU, 5'd16, 1'b1);
        load_row(4, LSU_LW, 32'h34, 5'd17);
        alu_row(5, DEST_PC4, 5'd18, 1'b1);
        alu_row(5, DEST_ALU, 5'd19, 1'b1);
        branch_row(32'h08);
        load_row(4, LSU_LW, 32'h20, 5'd20);
        alu_row(4, DEST_ALU, 5'd21, 1'b1);
        for (int k = 0; k < 4; k++) begin
            alu_row(5, DEST_ALU, reg_addr_t'(22 + k), 1'b1);
        end
        timeout_limit = RESET_CYCLES + 4 * n_rows + 50;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            compare(1, "rd_we_o", word_t'(rd_we_o), 32'h0);
            compare(1, "instr_valid_o", word_t'(instr_valid_o), 32'h0);
        end
        @(posedge clk);
        reset_n <= 1'b1;

        // A branch redirects fetch on the edge its result appears, so the read
        // returning in that same cycle must already count as stale.
        for (int i = 0; i < n_rows + 6; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                drive_row(i);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            if (i >= 2 && i - 2 < n_rows) begin
                check_row(i - 2);
            end else if (i < 2) begin
                compare(1, "rd_we_o", word_t'(rd_we_o), 32'h0);
            end
            check_fetch();
        end

        if (fetch_checks == 0 || redirects_done != 2 || redirect_pending) begin
            $display("Fetch did not deliver the expected instructions after redirects.");
            fail_count++;
            beh_errors[5]++;
        end

        $display("behavior 1 reset: %0d errors", beh_errors[1]);
        $display("behavior 2 ALU and PC+4 writeback: %0d errors", beh_errors[2]);
        $display("behavior 3 stores and loads: %0d errors", beh_errors[3]);
        $display("behavior 4 branch squash: %0d errors", beh_errors[4]);
        $display("behavior 5 fetch and redirect: %0d errors, %0d fetches",
                 beh_errors[5], fetch_checks);
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* mem_stage.f */
+incdir+rtl
rtl/rv_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/ex_mem_register.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/unified_ram.sv
rtl/writeback_select.sv
rtl/mem_stage_top.sv
test/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mem_stage.f --top-module tb_mem_stage -o tb_mem_stage

output=$(./obj_dir/tb_mem_stage)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi
